// File: hw/rob_pkg.sv
// shared types and flag positions for the retirement design, imported by each rtl file
package rob_pkg;

  // instruction address with the two low bits dropped
  typedef logic [29:0] pc_t;

  // result word from the execution units
  typedef logic [31:0] data_t;

  // retirement operation flags
  typedef logic [6:0] retop_t;

  // bit 5 set means no destination
  typedef logic [5:0] dest_t;

  // architectural register number
  typedef logic [4:0] reg_idx_t;

  // exception cause, decode causes are zero-extended into it
  typedef logic [4:0] ecause_t;

  // branch predictor tag
  typedef logic [15:0] bptag_t;

  // flag positions inside retop_t
  localparam int retop_branch = 6;
  localparam int retop_invert = 5;
  localparam int retop_jump   = 4;
  localparam int retop_store  = 3;

  // 128 entries
  localparam int rob_idx_bits_default = 7;

endpackage

// File: hw/rob_ifs.sv
// interfaces between the reorder buffer, the retirement controller and the trap registers
`timescale 1ns/1ns

// registered head entry from the buffer, flush back from the controller
interface retire_if import rob_pkg::*; #(
  parameter int rob_idx_bits = rob_idx_bits_default
) ();
  logic                    ret_valid;
  logic                    ret_error;
  retop_t                  ret_retop;
  pc_t                     ret_addr;
  dest_t                   ret_dest;
  ecause_t                 ret_ecause;
  data_t                   ret_result;
  pc_t                     ret_target;
  bptag_t                  ret_bptag;
  logic                    ret_bptaken;
  logic                    ret_forwarded;
  logic [rob_idx_bits-1:0] ret_slot;
  logic                    flush;

  modport buffer (
    output ret_valid, ret_error, ret_retop, ret_addr, ret_dest, ret_ecause,
    output ret_result, ret_target, ret_bptag, ret_bptaken, ret_forwarded,
    output ret_slot,
    input  flush
  );

  modport ctrl (
    input  ret_valid, ret_error, ret_retop, ret_addr, ret_dest, ret_ecause,
    input  ret_result, ret_target, ret_bptag, ret_bptaken, ret_forwarded,
    output flush
  );
endinterface

// trap request to the trap registers, trap vector back
interface trap_if import rob_pkg::*; ();
  logic    trap_valid;
  pc_t     trap_epc;
  ecause_t trap_cause;
  pc_t     tvec;

  modport ctrl (output trap_valid, trap_epc, trap_cause, input tvec);
  modport csr  (input trap_valid, trap_epc, trap_cause, output tvec);
endinterface

// File: hw/rob_buffer.sv
// reorder buffer storage: in-order entry at the tail, writeback by id, registered head read
`timescale 1ns/1ns

module rob_buffer import rob_pkg::*; #(
  parameter int rob_idx_bits = rob_idx_bits_default
) (
  input  logic                    clk,
  input  logic                    arst_n,

  // decode side
  input  logic                    decode_valid,
  input  logic                    decode_error,
  input  logic [1:0]              decode_ecause,
  input  retop_t                  decode_retop,
  input  pc_t                     decode_addr,
  input  dest_t                   decode_dest,
  input  bptag_t                  decode_bptag,
  input  logic                    decode_bptaken,
  input  logic                    decode_forward,
  input  pc_t                     decode_target,

  input  logic                    rename_inhibit,

  // writeback side
  input  logic                    wb_valid,
  input  logic                    wb_error,
  input  ecause_t                 wb_ecause,
  input  logic [rob_idx_bits-1:0] wb_rob_id,
  input  data_t                   wb_result,

  output logic                    rob_full,
  output logic [rob_idx_bits-1:0] rob_id,

  retire_if.buffer                ret
);

  localparam int depth = 1 << rob_idx_bits;

  typedef logic [rob_idx_bits-1:0] slot_t;
  // slot index plus wrap bit on top
  typedef logic [rob_idx_bits:0]   ptr_t;

  // per-slot storage
  logic    executed_q  [depth];
  logic    error_q     [depth];
  retop_t  retop_q     [depth];
  pc_t     addr_q      [depth];
  dest_t   dest_q      [depth];
  ecause_t ecause_q    [depth];
  data_t   result_q    [depth];
  pc_t     target_q    [depth];
  bptag_t  bptag_q     [depth];
  logic    bptaken_q   [depth];
  logic    forwarded_q [depth];

  ptr_t  head_ptr;
  ptr_t  tail_ptr;
  ptr_t  head_next;
  ptr_t  rd_ptr;
  slot_t rd_idx;
  logic  rd_avail;
  logic  buf_full;
  logic  decode_beat;
  logic  wb_accept;
  logic  inhibit_q;

  // same slot, opposite wrap bits
  assign buf_full = (head_ptr[rob_idx_bits-1:0] == tail_ptr[rob_idx_bits-1:0]) &&
                    (head_ptr[rob_idx_bits] != tail_ptr[rob_idx_bits]);

  assign decode_beat = decode_valid & ~buf_full;
  assign wb_accept   = wb_valid & ~inhibit_q;

  assign rob_full = buf_full;
  assign rob_id   = tail_ptr[rob_idx_bits-1:0];

  // read one ahead while the head is retiring, for back-to-back retirement
  assign head_next = ptr_t'(head_ptr + 1'b1);
  assign rd_ptr    = ret.ret_valid ? head_next : head_ptr;
  assign rd_idx    = rd_ptr[rob_idx_bits-1:0];
  // slot at the read pointer holds a live entry
  assign rd_avail  = (rd_ptr != tail_ptr);

  // pointers, delayed inhibit and read-stage valid
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      head_ptr      <= '0;
      tail_ptr      <= '0;
      inhibit_q     <= 1'b0;
      ret.ret_valid <= 1'b0;
    end else if (ret.flush) begin
      head_ptr      <= '0;
      tail_ptr      <= '0;
      inhibit_q     <= 1'b0;
      ret.ret_valid <= 1'b0;
    end else begin
      if (ret.ret_valid) begin
        head_ptr <= head_next;
      end
      if (decode_beat) begin
        tail_ptr <= ptr_t'(tail_ptr + 1'b1);
      end
      inhibit_q     <= rename_inhibit;
      ret.ret_valid <= executed_q[rd_idx] & rd_avail;
    end
  end

  // head entry payload
  always_ff @(posedge clk) begin
    ret.ret_error     <= error_q[rd_idx];
    ret.ret_retop     <= retop_q[rd_idx];
    ret.ret_addr      <= addr_q[rd_idx];
    ret.ret_dest      <= dest_q[rd_idx];
    ret.ret_ecause    <= ecause_q[rd_idx];
    ret.ret_result    <= result_q[rd_idx];
    ret.ret_target    <= target_q[rd_idx];
    ret.ret_bptag     <= bptag_q[rd_idx];
    ret.ret_bptaken   <= bptaken_q[rd_idx];
    ret.ret_forwarded <= forwarded_q[rd_idx];
    ret.ret_slot      <= rd_idx;
  end

  // slot writes; later statements win on the same slot
  always_ff @(posedge clk) begin
    // retired slot gives up its executed mark
    if (ret.ret_valid) begin
      executed_q[ret.ret_slot] <= 1'b0;
    end

    if (decode_beat) begin
      // errors and stores need no writeback
      executed_q[rob_id]  <= decode_error | decode_retop[retop_store];
      error_q[rob_id]     <= decode_error;
      retop_q[rob_id]     <= decode_retop;
      addr_q[rob_id]      <= decode_addr;
      dest_q[rob_id]      <= decode_dest;
      ecause_q[rob_id]    <= {3'b000, decode_ecause};
      target_q[rob_id]    <= decode_target;
      bptag_q[rob_id]     <= decode_bptag;
      bptaken_q[rob_id]   <= decode_bptaken;
      forwarded_q[rob_id] <= decode_forward;
    end

    if (wb_accept) begin
      executed_q[wb_rob_id] <= 1'b1;
      error_q[wb_rob_id]    <= wb_error;
      ecause_q[wb_rob_id]   <= wb_ecause;
      result_q[wb_rob_id]   <= wb_result;
    end
  end

endmodule

// File: hw/retire_ctrl.sv
// retirement decode of the head entry into commit, predictor, store, flush and trap outputs
`timescale 1ns/1ns

module retire_ctrl import rob_pkg::*; (
  retire_if.ctrl   ret,
  trap_if.ctrl     trap,

  output logic     flush,
  output pc_t      flush_pc,

  // register commit
  output logic     commit,
  output reg_idx_t commit_rd,
  output data_t    commit_result,

  // branch predictor update
  output logic     bp_update,
  output bptag_t   bp_tag,
  output logic     bp_taken,

  output logic     store_release
);

  logic ret_ok;
  logic ret_exc;
  logic br_outcome;
  logic mispredict;

  assign ret_ok  = ret.ret_valid & ~ret.ret_error;
  assign ret_exc = ret.ret_valid & ret.ret_error;

  // actual direction, bit 0 of the compare result
  assign br_outcome = ret.ret_result[0] ^ ret.ret_retop[retop_invert];

  // jumps always redirect, branches only on a wrong guess
  assign mispredict = ret.ret_valid &
                      (ret.ret_retop[retop_jump] |
                       (ret.ret_retop[retop_branch] & (br_outcome ^ ret.ret_bptaken)));

  assign flush     = ret_exc | mispredict;
  assign ret.flush = flush;

  // trap vector, forwarded register target, or decoded target
  always_comb begin
    if (ret.ret_error) begin
      flush_pc = trap.tvec;
    end else if (ret.ret_forwarded) begin
      flush_pc = ret.ret_result[31:2];
    end else begin
      flush_pc = ret.ret_target;
    end
  end

  assign commit    = ret_ok & ~ret.ret_dest[5];
  assign commit_rd = ret.ret_dest[4:0];
  // forwarded entries write the link address
  assign commit_result = ret.ret_forwarded ? {ret.ret_target, 2'b00} : ret.ret_result;

  assign bp_update = ret_ok & ret.ret_retop[retop_branch];
  assign bp_tag    = ret.ret_bptag;
  assign bp_taken  = br_outcome;

  assign store_release = ret_ok & ret.ret_retop[retop_store];

  assign trap.trap_valid = ret_exc;
  assign trap.trap_epc   = ret.ret_addr;
  assign trap.trap_cause = ret.ret_ecause;

endmodule

// File: hw/trap_csr.sv
// trap registers: externally written trap vector, plus trap pc and cause captured on exceptions
`timescale 1ns/1ns

module trap_csr import rob_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,

  // write port for the trap vector
  input  logic    tvec_we,
  input  pc_t     tvec_wdata,

  trap_if.csr     trap,

  output pc_t     trap_epc,
  output ecause_t trap_cause
);

  pc_t tvec_q;

  // trap vector
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tvec_q <= '0;
    end else if (tvec_we) begin
      tvec_q <= tvec_wdata;
    end
  end

  assign trap.tvec = tvec_q;

  // pc and cause of the last trapping entry
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      trap_epc   <= '0;
      trap_cause <= '0;
    end else if (trap.trap_valid) begin
      trap_epc   <= trap.trap_epc;
      trap_cause <= trap.trap_cause;
    end
  end

endmodule

// File: hw/retire_top.sv
// top level of the retirement end: reorder buffer, retirement controller and trap registers
`timescale 1ns/1ns

module retire_top import rob_pkg::*; #(
  parameter int rob_idx_bits = rob_idx_bits_default
) (
  input  logic                    clk,
  input  logic                    arst_n,

  // decode
  input  logic                    decode_valid,
  input  logic                    decode_error,
  input  logic [1:0]              decode_ecause,
  input  retop_t                  decode_retop,
  input  pc_t                     decode_addr,
  input  dest_t                   decode_dest,
  input  bptag_t                  decode_bptag,
  input  logic                    decode_bptaken,
  input  logic                    decode_forward,
  input  pc_t                     decode_target,
  output logic                    rob_full,
  output logic [rob_idx_bits-1:0] rob_id,

  input  logic                    rename_inhibit,

  // writeback
  input  logic                    wb_valid,
  input  logic                    wb_error,
  input  ecause_t                 wb_ecause,
  input  logic [rob_idx_bits-1:0] wb_rob_id,
  input  data_t                   wb_result,

  // trap vector write
  input  logic                    tvec_we,
  input  pc_t                     tvec_wdata,

  // retirement
  output logic                    ret_valid,
  output logic                    flush,
  output pc_t                     flush_pc,
  output logic                    commit,
  output reg_idx_t                commit_rd,
  output data_t                   commit_result,
  output logic                    bp_update,
  output bptag_t                  bp_tag,
  output logic                    bp_taken,
  output logic                    store_release,
  output pc_t                     trap_epc,
  output ecause_t                 trap_cause
);

  retire_if #(.rob_idx_bits(rob_idx_bits)) ret_bus ();
  trap_if trap_bus ();

  assign ret_valid = ret_bus.ret_valid;

  rob_buffer #(.rob_idx_bits(rob_idx_bits)) rob_buffer_inst (
    .clk            (clk),
    .arst_n         (arst_n),
    .decode_valid   (decode_valid),
    .decode_error   (decode_error),
    .decode_ecause  (decode_ecause),
    .decode_retop   (decode_retop),
    .decode_addr    (decode_addr),
    .decode_dest    (decode_dest),
    .decode_bptag   (decode_bptag),
    .decode_bptaken (decode_bptaken),
    .decode_forward (decode_forward),
    .decode_target  (decode_target),
    .rename_inhibit (rename_inhibit),
    .wb_valid       (wb_valid),
    .wb_error       (wb_error),
    .wb_ecause      (wb_ecause),
    .wb_rob_id      (wb_rob_id),
    .wb_result      (wb_result),
    .rob_full       (rob_full),
    .rob_id         (rob_id),
    .ret            (ret_bus.buffer)
  );

  retire_ctrl retire_ctrl_inst (
    .ret           (ret_bus.ctrl),
    .trap          (trap_bus.ctrl),
    .flush         (flush),
    .flush_pc      (flush_pc),
    .commit        (commit),
    .commit_rd     (commit_rd),
    .commit_result (commit_result),
    .bp_update     (bp_update),
    .bp_tag        (bp_tag),
    .bp_taken      (bp_taken),
    .store_release (store_release)
  );

  trap_csr trap_csr_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .tvec_we    (tvec_we),
    .tvec_wdata (tvec_wdata),
    .trap       (trap_bus.csr),
    .trap_epc   (trap_epc),
    .trap_cause (trap_cause)
  );

endmodule

// File: testbench/tb_retire_top.sv
// testbench for retire_top that replays the vector file and checks each retire event
`timescale 1ns/1ns

module tb_retire_top import rob_pkg::*; ();

  // about 300 cycles of directed tests plus the 128-beat fill and a wide margin
  localparam int max_cycles = 4000;

  logic           clk;
  logic           arst_n;
  logic           decode_valid;
  logic           decode_error;
  logic [1:0]     decode_ecause;
  retop_t         decode_retop;
  pc_t            decode_addr;
  dest_t          decode_dest;
  bptag_t         decode_bptag;
  logic           decode_bptaken;
  logic           decode_forward;
  pc_t            decode_target;
  logic           rob_full;
  logic [6:0]     rob_id;
  logic           rename_inhibit;
  logic           wb_valid;
  logic           wb_error;
  ecause_t        wb_ecause;
  logic [6:0]     wb_rob_id;
  data_t          wb_result;
  logic           tvec_we;
  pc_t            tvec_wdata;
  logic           ret_valid;
  logic           flush;
  pc_t            flush_pc;
  logic           commit;
  reg_idx_t       commit_rd;
  data_t          commit_result;
  logic           bp_update;
  bptag_t         bp_tag;
  logic           bp_taken;
  logic           store_release;
  pc_t            trap_epc;
  ecause_t        trap_cause;

  int cycles;
  int errors;
  int test_errors;
  int test_id;
  int tests_done;

  retire_top retire_top_inst (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout after %0d cycles, a retire never came", cycles);
      $display("test failed");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("error %s got %h expected %h (behavior %0d)", name, got, exp, test_id);
    errors++;
    test_errors++;
  endtask

  task automatic flag_failure(input string msg);
    $display("%s (behavior %0d)", msg, test_id);
    errors++;
    test_errors++;
  endtask

  task automatic clear_inputs();
    decode_valid   = 1'b0;
    decode_error   = 1'b0;
    decode_ecause  = '0;
    decode_retop   = '0;
    decode_addr    = '0;
    decode_dest    = '0;
    decode_bptag   = '0;
    decode_bptaken = 1'b0;
    decode_forward = 1'b0;
    decode_target  = '0;
    rename_inhibit = 1'b0;
    wb_valid       = 1'b0;
    wb_error       = 1'b0;
    wb_ecause      = '0;
    wb_rob_id      = '0;
    wb_result      = '0;
    tvec_we        = 1'b0;
    tvec_wdata     = '0;
  endtask

  task automatic close_test();
    if (test_id != 0) begin
      $display("behavior %0d finished with %0d errors", test_id, test_errors);
      tests_done++;
    end
    test_errors = 0;
  endtask

  // runs one record of the vector file and flags the end marker
  task automatic run_record(input int fd, output bit done);
    logic [7:0]  cmd;
    logic [31:0] a0, a1, a2, a3, a4, a5, a6, a7, a8;
    string       line;
    int          code;
    done = 1'b0;
    code = $fscanf(fd, " %c", cmd);
    if (code != 1) begin
      done = 1'b1;
    end else begin
      case (cmd)
        "#": code = $fgets(line, fd);
        "T": begin
          code = $fscanf(fd, "%d", a0);
          close_test();
          test_id = a0;
        end
        "D": begin
          code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", a0, a1, a2, a3, a4, a5, a6, a7, a8);
          decode_valid   = 1'b1;
          decode_error   = a0[0];
          decode_ecause  = a1[1:0];
          decode_retop   = a2[6:0];
          decode_addr    = a3[29:0];
          decode_dest    = a4[5:0];
          decode_bptag   = a5[15:0];
          decode_bptaken = a6[0];
          decode_forward = a7[0];
          decode_target  = a8[29:0];
          @(negedge clk);
          clear_inputs();
        end
        "W": begin
          code = $fscanf(fd, "%h %h %h %h", a0, a1, a2, a3);
          wb_valid  = 1'b1;
          wb_error  = a0[0];
          wb_ecause = a1[4:0];
          wb_rob_id = a2[6:0];
          wb_result = a3;
          @(negedge clk);
          clear_inputs();
        end
        "I": begin
          rename_inhibit = 1'b1;
          @(negedge clk);
          clear_inputs();
        end
        "V": begin
          code = $fscanf(fd, "%h", a0);
          tvec_we    = 1'b1;
          tvec_wdata = a0[29:0];
          @(negedge clk);
          clear_inputs();
        end
        "F": begin
          code = $fscanf(fd, "%h", a0);
          for (int i = 0; i < a0; i++) begin
            decode_valid = 1'b1;
            decode_addr  = pc_t'(32'h1000 + i);
            decode_dest  = 6'h20;
            @(negedge clk);
          end
          clear_inputs();
        end
        "Z": begin
          code = $fscanf(fd, "%h", a0);
          repeat (a0) begin
            if (ret_valid !== 1'b0) flag_failure("an entry retired that should not have");
            @(negedge clk);
          end
        end
        "K": begin
          code = $fscanf(fd, "%h", a0);
          if (rob_full !== a0[0]) report_mismatch("rob_full", rob_full, a0);
        end
        "Q": begin
          code = $fscanf(fd, "%h", a0);
          if (rob_id !== a0[6:0]) report_mismatch("rob_id", rob_id, a0);
        end
        "X": begin
          code = $fscanf(fd, "%h %h", a0, a1);
          if (trap_epc !== a0[29:0]) report_mismatch("trap_epc", trap_epc, a0);
          if (trap_cause !== a1[4:0]) report_mismatch("trap_cause", trap_cause, a1);
        end
        "R": begin
          code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", a0, a1, a2, a3, a4, a5, a6, a7, a8);
          while (ret_valid !== 1'b1) @(negedge clk);
          if (commit !== a0[0]) report_mismatch("commit", commit, a0);
          if (a0[0] && commit_rd !== a1[4:0]) report_mismatch("commit_rd", commit_rd, a1);
          if (a0[0] && commit_result !== a2) report_mismatch("commit_result", commit_result, a2);
          if (flush !== a3[0]) report_mismatch("flush", flush, a3);
          if (a3[0] && flush_pc !== a4[29:0]) report_mismatch("flush_pc", flush_pc, a4);
          if (bp_update !== a5[0]) report_mismatch("bp_update", bp_update, a5);
          if (a5[0] && bp_taken !== a6[0]) report_mismatch("bp_taken", bp_taken, a6);
          if (a5[0] && bp_tag !== a7[15:0]) report_mismatch("bp_tag", bp_tag, a7);
          if (store_release !== a8[0]) report_mismatch("store_release", store_release, a8);
          @(negedge clk);
        end
        "E": done = 1'b1;
        default: begin
          flag_failure("unknown record in the vector file");
          done = 1'b1;
        end
      endcase
    end
  endtask

  initial begin
    int fd;
    bit done;
    clk         = 1'b0;
    arst_n      = 1'b0;
    cycles      = 0;
    errors      = 0;
    test_errors = 0;
    test_id     = 0;
    tests_done  = 0;
    clear_inputs();
    repeat (16) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    // state right after reset
    if (ret_valid !== 1'b0) report_mismatch("ret_valid", ret_valid, 0);
    if (flush !== 1'b0) report_mismatch("flush", flush, 0);
    if (commit !== 1'b0) report_mismatch("commit", commit, 0);
    if (bp_update !== 1'b0) report_mismatch("bp_update", bp_update, 0);
    if (store_release !== 1'b0) report_mismatch("store_release", store_release, 0);
    if (rob_full !== 1'b0) report_mismatch("rob_full", rob_full, 0);
    if (trap_epc !== '0) report_mismatch("trap_epc", trap_epc, 0);
    if (trap_cause !== '0) report_mismatch("trap_cause", trap_cause, 0);

    fd = $fopen("testbench/retire_vectors.txt", "r");
    if (fd == 0) begin
      flag_failure("cannot open the vector file");
    end else begin
      done = 1'b0;
      while (!done) run_record(fd, done);
      $fclose(fd);
      close_test();
    end

    $display("%0d behaviors run, %0d errors", tests_done, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: testbench/retire_vectors.txt
# T id | D err ecause retop addr dest bptag bptaken fwd target | W err ecause id result
# R commit rd result flush flush_pc bp_update bp_taken bp_tag store | X epc cause | I V F Z K Q E
T 1
D 0 0 00 00000100 01 0000 0 0 00000000
D 0 0 00 00000101 02 0000 0 0 00000000
D 0 0 00 00000102 03 0000 0 0 00000000
D 0 0 00 00000103 20 0000 0 0 00000000
W 0 00 03 0000dddd
W 0 00 02 0000cccc
W 0 00 01 0000bbbb
Z 3
W 0 00 00 0000aaaa
R 1 01 0000aaaa 0 0 0 0 0 0
R 1 02 0000bbbb 0 0 0 0 0 0
R 1 03 0000cccc 0 0 0 0 0 0
R 0 00 00000000 0 0 0 0 0 0
T 5
D 0 0 08 00000200 20 0000 0 0 00000000
R 0 00 00000000 0 0 0 0 0 1
T 6
D 0 0 00 00000300 07 0000 0 0 00000000
I
W 0 00 05 11111111
Z 4
W 0 00 05 22222222
R 1 07 22222222 0 0 0 0 0 0
T 3
D 0 0 40 00000400 20 1234 1 0 00000500
W 0 00 06 00000001
R 0 00 00000000 0 0 1 1 1234 0
D 0 0 40 00000410 20 5678 0 0 00000600
D 0 0 00 00000411 08 0000 0 0 00000000
D 0 0 00 00000412 09 0000 0 0 00000000
W 0 00 08 00000001
W 0 00 09 00000002
Z 3
W 0 00 07 00000001
R 0 00 00000000 1 00000600 1 1 5678 0
Z 6
D 0 0 10 00000700 05 0000 0 1 00000701
W 0 00 00 00004008
R 1 05 00001c04 1 00001002 0 0 0 0
T 4
V 01000000
D 1 2 00 00000040 01 0000 0 0 00000000
R 0 00 00000000 1 01000000 0 0 0 0
X 00000040 02
D 0 0 00 00000080 02 0000 0 0 00000000
W 1 11 00 00000000
R 0 00 00000000 1 01000000 0 0 0 0
X 00000080 11
T 2
F 80
K 1
Q 00
D 0 0 00 00000999 01 0000 0 0 00000000
Q 00
K 1
W 0 00 00 00000055
R 0 00 00000000 0 0 0 0 0 0
K 0
E

// File: src.f
hw/rob_pkg.sv
hw/rob_ifs.sv
hw/rob_buffer.sv
hw/retire_ctrl.sv
hw/trap_csr.sv
hw/retire_top.sv
testbench/tb_retire_top.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f src.f --top-module tb_retire_top -o tb_retire_top
	./obj_dir/tb_retire_top | tee sim.log
	grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
